/* design/board_io_cfg.svh */
/*
 * Board input conditioning configuration
 * Stage counts and debounce settings shared by the RTL and the testbench
 */

`ifndef BOARD_IO_CFG_SVH
`define BOARD_IO_CFG_SVH

// Cycles the synchronous reset is held after lock and reset release
`define SYNC_RESET_STAGES 4

// Depth of the pin synchronizer chain
`define SIGNAL_SYNC_STAGES 2

// Number of agreeing samples before a debounced output changes
`define DEBOUNCE_SAMPLES 4

// Clock cycles between debounce sample ticks (1 ms at 125 MHz)
`define DEBOUNCE_RATE 125000

`endif

/* design/board_io_pkg.sv */
/*
 * Board I/O types
 * Packed groups for the push buttons, switches and UART pins
 */

package board_io_pkg;

    // Number of slide switches on the board
    localparam int SW_WIDTH = 4;

    // Buttons and switches, ordered as they appear on the board header
    typedef struct packed {
        logic                btnu;
        logic                btnl;
        logic                btnd;
        logic                btnr;
        logic                btnc;
        logic [SW_WIDTH-1:0] sw;
    } gpio_t;

    // Total number of debounced inputs
    localparam int GPIO_WIDTH = $bits(gpio_t);

    // UART receive and clear-to-send from the USB bridge
    typedef struct packed {
        logic rxd;
        logic cts;
    } uart_pins_t;

endpackage

/* design/signal_sync.sv */
/*
 * Pin synchronizer
 * Register chain that brings asynchronous board pins into the clock domain
 */

`include "board_io_cfg.svh"

module signal_sync
    import board_io_pkg::*;
#(
    parameter type T      = gpio_t,
    parameter int  STAGES = `SIGNAL_SYNC_STAGES
) (
    input  logic clk_125mhz_i,
    input  T     in_i,
    output T     out_o
);

    // First stage may go metastable, later stages settle it
    T sync_q [STAGES];

    always_ff @(posedge clk_125mhz_i) begin
        sync_q[0] <= in_i;
        for (int i = 1; i < STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    assign out_o = sync_q[STAGES-1];

endmodule

/* design/reset_sync.sv */
/*
 * Reset synchronizer
 * Asserts reset at once on reset or loss of lock, releases it on the clock
 */

`include "board_io_cfg.svh"

module reset_sync (
    input  logic clk_125mhz_i,
    input  logic arst_n_i,
    input  logic mmcm_locked_i,
    output logic rst_o
);

    localparam int STAGES = `SYNC_RESET_STAGES;

    logic              rst_in_n;
    logic [STAGES-1:0] rst_shift_q;

    // Either source pulls the chain back to all ones
    assign rst_in_n = arst_n_i & mmcm_locked_i;

    // Zeros walk in from the bottom once both sources are released
    always_ff @(posedge clk_125mhz_i or negedge rst_in_n) begin
        if (!rst_in_n) begin
            rst_shift_q <= '1;
        end else begin
            rst_shift_q <= {rst_shift_q[STAGES-2:0], 1'b0};
        end
    end

    // Last stage drives the reset, so release lands after STAGES edges
    assign rst_o = rst_shift_q[STAGES-1];

endmodule

/* design/debounce_timer.sv */
/*
 * Debounce sample timer
 * Free-running counter, one-cycle tick every RATE clock cycles
 */

module debounce_timer #(
    parameter int RATE = 125000
) (
    input  logic clk_125mhz_i,
    input  logic arst_n_i,
    input  logic rst_i,
    output logic sample_tick_o
);

    localparam int CNT_W = (RATE > 1) ? $clog2(RATE) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RATE - 1);

    logic [CNT_W-1:0] cnt_q;
    logic             tick_q;

    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end else if (rst_i) begin
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end else if (cnt_q == CNT_LAST) begin
            // Wrap and fire the tick for a single cycle
            cnt_q  <= '0;
            tick_q <= 1'b1;
        end else begin
            cnt_q  <= cnt_q + 1'b1;
            tick_q <= 1'b0;
        end
    end

    assign sample_tick_o = tick_q;

endmodule

/* design/debounce_filter.sv */
/*
 * N-sample debounce filter
 * Output bit follows its input only after N agreeing samples
 */

module debounce_filter
    import board_io_pkg::*;
#(
    parameter int N = 4
) (
    input  logic  clk_125mhz_i,
    input  logic  arst_n_i,
    input  logic  rst_i,
    input  logic  sample_tick_i,
    input  gpio_t raw_i,
    output gpio_t clean_o
);

    logic [GPIO_WIDTH-1:0]         raw_bits;
    logic [GPIO_WIDTH-1:0][N-1:0]  hist_q;
    logic [GPIO_WIDTH-1:0]         clean_q;

    assign raw_bits = raw_i;

    // Sample history, newest sample in bit 0
    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist_q <= '0;
        end else if (rst_i) begin
            hist_q <= '0;
        end else if (sample_tick_i) begin
            for (int i = 0; i < GPIO_WIDTH; i++) begin
                hist_q[i] <= {hist_q[i][N-2:0], raw_bits[i]};
            end
        end
    end

    // A bit moves only on a unanimous history, else it holds
    always_ff @(posedge clk_125mhz_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            clean_q <= '0;
        end else if (rst_i) begin
            clean_q <= '0;
        end else begin
            for (int i = 0; i < GPIO_WIDTH; i++) begin
                if (&hist_q[i]) begin
                    clean_q[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    clean_q[i] <= 1'b0;
                end
            end
        end
    end

    assign clean_o = clean_q;

endmodule

/* design/board_io_top.sv */
/*
 * Board input conditioning top level
 * Reset release, pin synchronizers and button/switch debouncing
 */

`include "board_io_cfg.svh"

module board_io_top
    import board_io_pkg::*;
#(
    parameter int RATE = `DEBOUNCE_RATE
) (
    input  logic       clk_125mhz_i,
    input  logic       arst_n_i,
    input  logic       mmcm_locked_i,

    // Raw buttons and switches
    input  gpio_t      gpio_i,

    // Raw UART pins
    input  logic       uart_rxd_i,
    input  logic       uart_cts_i,

    output logic       rst_o,
    output logic [4:0] btn_o,
    output logic [3:0] sw_o,
    output logic       uart_rxd_o,
    output logic       uart_cts_o
);

    logic       rst;
    logic       sample_tick;
    gpio_t      gpio_sync_q;
    gpio_t      gpio_clean;
    uart_pins_t uart_raw;
    uart_pins_t uart_sync_q;

    // Synchronous reset for the 125 MHz domain
    reset_sync i_reset_sync (
        .clk_125mhz_i  (clk_125mhz_i),
        .arst_n_i      (arst_n_i),
        .mmcm_locked_i (mmcm_locked_i),
        .rst_o         (rst)
    );

    assign rst_o = rst;

    // UART pins only need synchronizing, no debounce
    assign uart_raw = {uart_rxd_i, uart_cts_i};

    signal_sync #(
        .T (uart_pins_t)
    ) uart_sync (
        .clk_125mhz_i (clk_125mhz_i),
        .in_i         (uart_raw),
        .out_o        (uart_sync_q)
    );

    assign uart_rxd_o = uart_sync_q.rxd;
    assign uart_cts_o = uart_sync_q.cts;

    // Buttons and switches
    signal_sync #(
        .T (gpio_t)
    ) gpio_sync (
        .clk_125mhz_i (clk_125mhz_i),
        .in_i         (gpio_i),
        .out_o        (gpio_sync_q)
    );

    // One timer paces every filter bit
    debounce_timer #(
        .RATE (RATE)
    ) i_debounce_timer (
        .clk_125mhz_i  (clk_125mhz_i),
        .arst_n_i      (arst_n_i),
        .rst_i         (rst),
        .sample_tick_o (sample_tick)
    );

    debounce_filter #(
        .N (`DEBOUNCE_SAMPLES)
    ) i_debounce_filter (
        .clk_125mhz_i  (clk_125mhz_i),
        .arst_n_i      (arst_n_i),
        .rst_i         (rst),
        .sample_tick_i (sample_tick),
        .raw_i         (gpio_sync_q),
        .clean_o       (gpio_clean)
    );

    // Split the clean group into button and switch outputs
    assign btn_o = {gpio_clean.btnu,
                    gpio_clean.btnl,
                    gpio_clean.btnd,
                    gpio_clean.btnr,
                    gpio_clean.btnc};
    assign sw_o  = gpio_clean.sw;

endmodule

/* verif/board_io_props.sv */
/*
 * Board I/O assertions
 * Reset release and sample tick timing rules, bound into the top level
 */

`include "board_io_cfg.svh"

module board_io_props (
    input logic clk_i,
    input logic arst_n_i,
    input logic mmcm_locked_i,
    input logic rst_i,
    input logic sample_tick_i
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int STAGES = `SYNC_RESET_STAGES;

    int   fail_count = 0;
    logic released;

    assign released = arst_n_i & mmcm_locked_i;

    // Lock loss holds the domain in reset
    a_reset_on_unlock: assert property (@(posedge clk_i) !mmcm_locked_i |-> rst_i)
        else begin
            fail_count++;
            $error("rst_o low while mmcm_locked_i is low");
        end

    // Release edge lands exactly STAGES clocks after both sources go high
    a_release_delay: assert property (@(posedge clk_i)
        (released && $past(released, STAGES) && !$past(released, STAGES + 1))
        |-> $fell(rst_i))
        else begin
            fail_count++;
            $error("rst_o did not fall %0d cycles after release", STAGES);
        end

    a_tick_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        sample_tick_i |=> !sample_tick_i)
        else begin
            fail_count++;
            $error("sample tick high for two cycles in a row");
        end

endmodule

bind board_io_top board_io_props i_board_io_props (
    .clk_i         (clk_125mhz_i),
    .arst_n_i      (arst_n_i),
    .mmcm_locked_i (mmcm_locked_i),
    .rst_i         (rst_o),
    .sample_tick_i (sample_tick)
);

/* verif/board_io_checker.sv */
/*
 * Board I/O checker
 * Compares DUT outputs with the expected table values and the UART pin history
 */

`include "board_io_cfg.svh"

module board_io_checker
    import board_io_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       mmcm_locked_i,
    input  logic       uart_rxd_i,
    input  logic       uart_cts_i,
    input  logic       dut_rst_i,
    input  logic [4:0] dut_btn_i,
    input  logic [3:0] dut_sw_i,
    input  logic       dut_rxd_i,
    input  logic       dut_cts_i,
    input  logic       check_en_i,
    input  logic       steady_en_i,
    input  int         test_id_i,
    input  logic       exp_rst_i,
    input  logic [4:0] exp_btn_i,
    input  logic [3:0] exp_sw_i,
    output int         tests_o,
    output int         errors_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH      = `SIGNAL_SYNC_STAGES;
    localparam int RST_STAGES = `SYNC_RESET_STAGES;

    uart_pins_t uart_hist [DEPTH];
    int         fill_cnt    = 0;
    int         release_cnt = 0;
    logic       rst_prev    = 1'b0;
    int         test_errs   = 0;
    int         test_total  = 0;
    int         error_total = 0;

    assign tests_o  = test_total;
    assign errors_o = error_total;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR time=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        test_errs++;
        error_total++;
    endtask

    always @(posedge clk_i) begin
        uart_pins_t expected_uart;
        expected_uart = uart_hist[DEPTH-1];

        // UART outputs trail the pins by the chain depth
        if (fill_cnt >= DEPTH) begin
            if (dut_rxd_i !== expected_uart.rxd)
                report_mismatch("uart_rxd_o", expected_uart.rxd, dut_rxd_i);
            if (dut_cts_i !== expected_uart.cts)
                report_mismatch("uart_cts_o", expected_uart.cts, dut_cts_i);
        end

        // Debounced outputs cleared one clock into reset
        if (dut_rst_i && rst_prev) begin
            if (dut_btn_i !== 5'b0)
                report_mismatch("btn_o", 0, dut_btn_i);
            if (dut_sw_i !== 4'b0)
                report_mismatch("sw_o", 0, dut_sw_i);
        end

        // Count the clocks rst_o stays high once both sources are released
        if (arst_n_i && mmcm_locked_i) begin
            if (dut_rst_i) begin
                release_cnt <= release_cnt + 1;
            end else if (release_cnt != 0) begin
                if (release_cnt != RST_STAGES)
                    report_mismatch("rst_o release cycles", RST_STAGES, release_cnt);
                release_cnt <= 0;
            end
        end else begin
            release_cnt <= 0;
        end

        if (check_en_i) begin
            if (dut_rst_i !== exp_rst_i)
                report_mismatch("rst_o", exp_rst_i, dut_rst_i);
            if (dut_btn_i !== exp_btn_i)
                report_mismatch("btn_o", exp_btn_i, dut_btn_i);
            if (dut_sw_i !== exp_sw_i)
                report_mismatch("sw_o", exp_sw_i, dut_sw_i);
            test_total++;
            if (test_errs == 0) begin
                $display("Test %0d: pass", test_id_i);
            end else begin
                $display("Test %0d: FAIL with %0d errors", test_id_i, test_errs);
            end
            test_errs = 0;
        end else if (steady_en_i) begin
            // A short glitch must not move a debounced output at any point
            if (dut_btn_i !== exp_btn_i)
                report_mismatch("btn_o", exp_btn_i, dut_btn_i);
            if (dut_sw_i !== exp_sw_i)
                report_mismatch("sw_o", exp_sw_i, dut_sw_i);
        end

        uart_hist[0] <= uart_pins_t'({uart_rxd_i, uart_cts_i});
        for (int i = 1; i < DEPTH; i++) begin
            uart_hist[i] <= uart_hist[i-1];
        end
        if (fill_cnt < DEPTH) begin
            fill_cnt <= fill_cnt + 1;
        end
        rst_prev <= dut_rst_i;
    end

endmodule

/* verif/board_io_tb.sv */
/*
 * Board I/O testbench
 * Table-driven levels, lock loss and random short glitches on buttons and switches
 */

`include "board_io_cfg.svh"

module board_io_tb
    import board_io_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RATE         = 8;
    localparam int RESET_CYCLES = 10;
    localparam int MARGIN       = 200;

    typedef struct {
        gpio_t      gpio;
        logic       rxd;
        logic       cts;
        logic       lock;
        logic       glitch;
        int         hold;
        logic       exp_rst;
        logic [4:0] exp_btn;
        logic [3:0] exp_sw;
    } test_entry_t;

    logic        clk;
    logic        arst_n;
    logic        mmcm_locked;
    gpio_t       gpio_pins;
    logic        uart_rxd;
    logic        uart_cts;
    logic        dut_rst;
    logic [4:0]  dut_btn;
    logic [3:0]  dut_sw;
    logic        dut_rxd;
    logic        dut_cts;

    logic        check_en;
    logic        steady_en;
    int          test_id;
    logic        exp_rst;
    logic [4:0]  exp_btn;
    logic [3:0]  exp_sw;
    int          checked_tests;
    int          check_errors;

    test_entry_t tests_q [$];
    logic [31:0] rng_state   = 32'h5fae_69ab;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_test(input gpio_t gpio_val, input logic rxd, input logic cts,
                            input logic lock, input logic glitch, input int hold,
                            input logic rst_val, input logic [4:0] btn_val,
                            input logic [3:0] sw_val);
        test_entry_t e;
        e = '{gpio_val, rxd, cts, lock, glitch, hold, rst_val, btn_val, sw_val};
        tests_q.push_back(e);
    endtask

    task automatic load_table();
        //       gpio          rxd   cts   lock  glitch hold rst   btn       sw
        add_test(9'b00000_0000, 1'b1, 1'b0, 1'b1, 1'b0, 60, 1'b0, 5'b00000, 4'b0000);
        add_test(9'b10100_0101, 1'b0, 1'b1, 1'b1, 1'b0, 60, 1'b0, 5'b10100, 4'b0101);
        add_test(9'b10100_0101, 1'b0, 1'b1, 1'b1, 1'b1, 60, 1'b0, 5'b10100, 4'b0101);
        add_test(9'b01011_1010, 1'b1, 1'b1, 1'b1, 1'b0, 60, 1'b0, 5'b01011, 4'b1010);
        add_test(9'b01011_1010, 1'b1, 1'b0, 1'b1, 1'b1, 60, 1'b0, 5'b01011, 4'b1010);
        // Lock loss in mid run followed by recovery
        add_test(9'b01011_1010, 1'b0, 1'b0, 1'b0, 1'b0, 20, 1'b1, 5'b00000, 4'b0000);
        add_test(9'b01011_1010, 1'b1, 1'b0, 1'b1, 1'b0, 70, 1'b0, 5'b01011, 4'b1010);
        add_test(9'b11111_1111, 1'b0, 1'b1, 1'b1, 1'b0, 60, 1'b0, 5'b11111, 4'b1111);
        add_test(9'b11111_1111, 1'b1, 1'b1, 1'b1, 1'b1, 60, 1'b0, 5'b11111, 4'b1111);
        add_test(9'b00000_0000, 1'b0, 1'b0, 1'b1, 1'b0, 60, 1'b0, 5'b00000, 4'b0000);
        add_test(9'b00000_0000, 1'b1, 1'b0, 1'b1, 1'b1, 60, 1'b0, 5'b00000, 4'b0000);
        add_test(9'b00110_1100, 1'b0, 1'b1, 1'b1, 1'b0, 60, 1'b0, 5'b00110, 4'b1100);
    endtask

    function automatic int total_cycles();
        int sum;
        sum = RESET_CYCLES;
        foreach (tests_q[i]) begin
            sum += tests_q[i].hold + 1;
        end
        return sum;
    endfunction

    task automatic run_entry(input int idx);
        test_entry_t e;
        int          glitch_len;
        gpio_t       glitch_mask;
        e = tests_q[idx];
        glitch_len = 0;
        uart_rxd    <= e.rxd;
        uart_cts    <= e.cts;
        mmcm_locked <= e.lock;
        exp_rst     <= e.exp_rst;
        exp_btn     <= e.exp_btn;
        exp_sw      <= e.exp_sw;
        steady_en   <= e.glitch;
        if (e.glitch) begin
            // Nonzero mask and a pulse shorter than one sample period
            rng_state   = xorshift32(rng_state);
            glitch_mask = gpio_t'(rng_state[8:0] | 9'h001);
            rng_state   = xorshift32(rng_state);
            glitch_len  = 1 + int'(rng_state % (RATE - 1));
            gpio_pins <= gpio_t'(e.gpio ^ glitch_mask);
            repeat (glitch_len) @(posedge clk);
        end
        gpio_pins <= e.gpio;
        repeat (e.hold - glitch_len) @(posedge clk);
        check_en <= 1'b1;
        test_id  <= idx;
        @(posedge clk);
        check_en  <= 1'b0;
        steady_en <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int fail_total;
        arst_n      = 1'b0;
        mmcm_locked = 1'b1;
        gpio_pins   = '0;
        uart_rxd    = 1'b1;
        uart_cts    = 1'b0;
        check_en    = 1'b0;
        steady_en   = 1'b0;
        test_id     = 0;
        exp_rst     = 1'b1;
        exp_btn     = '0;
        exp_sw      = '0;
        load_table();
        cycle_limit = total_cycles() + MARGIN;

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        foreach (tests_q[i]) begin
            run_entry(i);
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        fail_total = check_errors + i_board_io_top.i_board_io_props.fail_count;
        $display("Summary: %0d tests, %0d check errors, %0d assertion failures",
                 checked_tests, check_errors, i_board_io_top.i_board_io_props.fail_count);
        if (fail_total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    board_io_top #(
        .RATE (RATE)
    ) i_board_io_top (
        .clk_125mhz_i  (clk),
        .arst_n_i      (arst_n),
        .mmcm_locked_i (mmcm_locked),
        .gpio_i        (gpio_pins),
        .uart_rxd_i    (uart_rxd),
        .uart_cts_i    (uart_cts),
        .rst_o         (dut_rst),
        .btn_o         (dut_btn),
        .sw_o          (dut_sw),
        .uart_rxd_o    (dut_rxd),
        .uart_cts_o    (dut_cts)
    );

    board_io_checker i_board_io_checker (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .mmcm_locked_i (mmcm_locked),
        .uart_rxd_i    (uart_rxd),
        .uart_cts_i    (uart_cts),
        .dut_rst_i     (dut_rst),
        .dut_btn_i     (dut_btn),
        .dut_sw_i      (dut_sw),
        .dut_rxd_i     (dut_rxd),
        .dut_cts_i     (dut_cts),
        .check_en_i    (check_en),
        .steady_en_i   (steady_en),
        .test_id_i     (test_id),
        .exp_rst_i     (exp_rst),
        .exp_btn_i     (exp_btn),
        .exp_sw_i      (exp_sw),
        .tests_o       (checked_tests),
        .errors_o      (check_errors)
    );

endmodule

/* src.f */
+incdir+design
design/board_io_pkg.sv
design/signal_sync.sv
design/reset_sync.sv
design/debounce_timer.sv
design/debounce_filter.sv
design/board_io_top.sv
verif/board_io_props.sv
verif/board_io_checker.sv
verif/board_io_tb.sv

/* Makefile */
# Verilator build and run for the board I/O conditioning project

VERILATOR ?= verilator
TOP       ?= board_io_tb
DUT_TOP   ?= board_io_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE) -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
